/* sim.f */
+incdir+src
src/ffe_pkg.sv
src/ffe_coef_regs.sv
src/ffe_tap_window.sv
src/ffe_lane.sv
src/ffe_top.sv
testbench/ffe_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert
LINTFLAGS ?= --lint-only --timing
TOP       := ffe_tb
RTL_TOP   := ffe_top
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation FAILED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Failure found in $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/ffe_tb.sv */
`timescale 1ns/1ps

`include "ffe_consts.svh"

module ffe_tb;

   localparam int HIST_LEN    = `FFE_LENGTH - 1;
   localparam int RESULT_MAX  = (1 << (`FFE_RESULT_BITS - 1)) - 1;
   localparam int RESULT_MIN  = -(1 << (`FFE_RESULT_BITS - 1));
   localparam int DRAIN_LIMIT = 50;  // Cycles allowed for the last word to come out

   logic                  clk;
   logic                  reset;
   ffe_pkg::code_word_t   codes;
   logic                  codes_valid;
   ffe_pkg::coef_wr_t     coef_wr;
   logic                  coef_wr_valid;
   ffe_pkg::result_word_t results;
   logic                  results_valid;

   // Testbench copy of the coefficient tables and of the serial stream
   int model_weight [`FFE_LENGTH][`FFE_WIDTH];
   int model_shift [`FFE_WIDTH];
   int model_hist [HIST_LEN];  // Index 0 is the oldest code

   ffe_pkg::result_word_t expected_q [$];

   int seed = 32'hea95;
   int error_count = 0;
   int check_count = 0;
   int recv_count = 0;

   ffe_top dut_i (
      .clk           (clk),
      .reset         (reset),
      .codes         (codes),
      .codes_valid   (codes_valid),
      .coef_wr       (coef_wr),
      .coef_wr_valid (coef_wr_valid),
      .results       (results),
      .results_valid (results_valid)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Each lane sums weight times the code that many places back in the stream,
   // then shifts right with sign fill and clamps to the result range
   function automatic ffe_pkg::result_word_t expected_word(input ffe_pkg::code_word_t word);
      ffe_pkg::result_word_t exp_word;
      int serial [HIST_LEN + `FFE_WIDTH];
      int sum;
      for (int i = 0; i < HIST_LEN; i++) begin
         serial[i] = model_hist[i];
      end
      for (int l = 0; l < `FFE_WIDTH; l++) begin
         serial[HIST_LEN + l] = int'($signed(word.code[l]));
      end
      for (int l = 0; l < `FFE_WIDTH; l++) begin
         sum = 0;
         for (int t = 0; t < `FFE_LENGTH; t++) begin
            sum += model_weight[t][l] * serial[HIST_LEN + l - t];
         end
         sum = sum >>> model_shift[l];
         if (sum > RESULT_MAX) sum = RESULT_MAX;
         if (sum < RESULT_MIN) sum = RESULT_MIN;
         exp_word.result[l] = ffe_pkg::result_t'(sum);
      end
      return exp_word;
   endfunction

   function automatic ffe_pkg::code_word_t random_word();
      ffe_pkg::code_word_t word;
      for (int l = 0; l < `FFE_WIDTH; l++) begin
         word.code[l] = ffe_pkg::code_t'($random(seed));
      end
      return word;
   endfunction

   function automatic ffe_pkg::code_word_t flat_word(input int code);
      ffe_pkg::code_word_t word;
      for (int l = 0; l < `FFE_WIDTH; l++) begin
         word.code[l] = ffe_pkg::code_t'(code);
      end
      return word;
   endfunction

   task automatic write_cfg(input logic kind, input int tap, input int lane, input int value);
      ffe_pkg::coef_wr_t wr;
      wr.kind  = kind;
      wr.tap   = ffe_pkg::tap_idx_t'(tap);
      wr.lane  = ffe_pkg::lane_idx_t'(lane);
      wr.value = ffe_pkg::weight_t'(value);
      @(posedge clk);
      coef_wr       <= wr;
      coef_wr_valid <= 1'b1;
      @(posedge clk);
      coef_wr_valid <= 1'b0;
      // A weight write to a tap past the last one is dropped by the bank
      if (kind == `FFE_KIND_SHIFT) begin
         model_shift[lane] = value & ((1 << `FFE_SHIFT_BITS) - 1);
      end else if (tap < `FFE_LENGTH) begin
         model_weight[tap][lane] = int'(ffe_pkg::weight_t'(value));
      end
   endtask

   task automatic send_word(input ffe_pkg::code_word_t word);
      @(posedge clk);
      codes       <= word;
      codes_valid <= 1'b1;
      expected_q.push_back(expected_word(word));
      for (int i = 0; i < HIST_LEN; i++) begin
         model_hist[i] = int'($signed(word.code[`FFE_WIDTH - HIST_LEN + i]));
      end
   endtask

   task automatic end_burst();
      @(posedge clk);
      codes_valid <= 1'b0;
   endtask

   task automatic send_random_burst(input int count);
      for (int n = 0; n < count; n++) begin
         send_word(random_word());
      end
      end_burst();
   endtask

   task automatic drain(input string what);
      int cycles;
      cycles = 0;
      while (expected_q.size() != 0 && cycles < DRAIN_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      if (expected_q.size() != 0) begin
         $display("Timeout: %0d result word(s) never arrived during %s",
                  expected_q.size(), what);
         error_count++;
         expected_q.delete();  // Later tests start from an empty queue
      end
   endtask

   task automatic report_test(input int num, input string name);
      $display("Test %0d (%s) finished, %0d errors so far", num, name, error_count);
   endtask

   // Results are sampled on the falling edge, half a cycle after they settle
   always @(negedge clk) begin : compare
      ffe_pkg::result_word_t exp_word;
      if (results_valid) begin
         recv_count++;
         if (expected_q.size() == 0) begin
            $display("Error at %0t ns: results_valid arrived with no code word outstanding",
                     $time);
            error_count++;
         end else begin
            exp_word = expected_q.pop_front();
            for (int l = 0; l < `FFE_WIDTH; l++) begin
               check_count++;
               assert (results.result[l] === exp_word.result[l]) else begin
                  $display("FAILED at %0t ns: lane %0d expected %0d, got %0d", $time, l,
                           $signed(exp_word.result[l]), $signed(results.result[l]));
                  error_count++;
               end
            end
         end
      end
   end

   initial begin
      int recv_before;
      reset         = 1'b1;
      codes         = '0;
      codes_valid   = 1'b0;
      coef_wr       = '0;
      coef_wr_valid = 1'b0;
      for (int t = 0; t < `FFE_LENGTH; t++) begin
         for (int l = 0; l < `FFE_WIDTH; l++) begin
            model_weight[t][l] = 0;
         end
      end
      for (int l = 0; l < `FFE_WIDTH; l++) model_shift[l] = 0;
      for (int i = 0; i < HIST_LEN; i++) model_hist[i] = 0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;

      // Nothing may come out before the first word goes in
      for (int n = 0; n < 10; n++) begin
         @(negedge clk);
         check_count++;
         assert (!results_valid) else begin
            $display("FAILED at %0t ns: results_valid high before any code word", $time);
            error_count++;
         end
      end
      send_random_burst(8);
      drain("zero weights");
      report_test(1, "zero weights after reset");

      for (int l = 0; l < `FFE_WIDTH; l++) write_cfg(`FFE_KIND_WEIGHT, 0, l, 1);
      recv_before = recv_count;
      for (int n = 0; n < 10; n++) begin
         send_word(random_word());
         end_burst();
      end
      drain("identity");
      repeat (4) @(posedge clk);  // A surplus strobe would still be counted here
      check_count++;
      assert (recv_count - recv_before == 10) else begin
         $display("FAILED at %0t ns: %0d result words for 10 code words", $time,
                  recv_count - recv_before);
         error_count++;
      end
      report_test(2, "identity");

      for (int t = 0; t < `FFE_LENGTH; t++) begin
         for (int l = 0; l < `FFE_WIDTH; l++) begin
            write_cfg(`FFE_KIND_WEIGHT, t, l, ($random(seed) & 63) - 32);
         end
      end
      for (int l = 0; l < `FFE_WIDTH; l++) write_cfg(`FFE_KIND_SHIFT, 0, l, 4);
      send_random_burst(20);
      drain("multi-tap");
      report_test(3, "multi-tap back to back");

      for (int t = 0; t < `FFE_LENGTH; t++) begin
         for (int l = 0; l < `FFE_WIDTH; l++) begin
            write_cfg(`FFE_KIND_WEIGHT, t, l, ($random(seed) & 127) - 64);
         end
      end
      for (int l = 0; l < `FFE_WIDTH; l++) write_cfg(`FFE_KIND_SHIFT, 0, l, 5 + l);
      send_random_burst(16);
      drain("per-lane shift");
      report_test(4, "per-lane shifts");

      // Full-scale weights push every lane past both limits
      for (int t = 0; t < `FFE_LENGTH; t++) begin
         for (int l = 0; l < `FFE_WIDTH; l++) write_cfg(`FFE_KIND_WEIGHT, t, l, 511);
      end
      for (int l = 0; l < `FFE_WIDTH; l++) write_cfg(`FFE_KIND_SHIFT, 0, l, 0);
      for (int n = 0; n < 3; n++) send_word(flat_word(127));
      for (int n = 0; n < 3; n++) send_word(flat_word(-128));
      send_random_burst(6);
      drain("saturation");
      report_test(5, "saturation");

      for (int l = 0; l < `FFE_WIDTH; l++) begin
         write_cfg(`FFE_KIND_WEIGHT, 0, l, 2);
         write_cfg(`FFE_KIND_WEIGHT, 1, l, -1);
         write_cfg(`FFE_KIND_WEIGHT, 2, l, 0);
         write_cfg(`FFE_KIND_SHIFT, 0, l, 1);
      end
      send_random_burst(8);
      drain("first reconfigured burst");
      for (int l = 0; l < `FFE_WIDTH; l++) begin
         write_cfg(`FFE_KIND_WEIGHT, 0, l, -3);
         write_cfg(`FFE_KIND_WEIGHT, 2, l, 1 + l);
         write_cfg(`FFE_KIND_WEIGHT, 3, l, 100);  // Tap 3 does not exist
      end
      send_random_burst(8);
      drain("second reconfigured burst");
      report_test(6, "reconfiguration");

      $display("Checks: %0d, words: %0d, errors: %0d", check_count, recv_count, error_count);
      if (error_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* src/ffe_top.sv */
`timescale 1ns/1ps

`include "ffe_consts.svh"

// Parallel feed-forward equalizer.
// Every word of FFE_WIDTH codes comes out as FFE_WIDTH equalized results
// two cycles after the strobe that carried it.
module ffe_top (
   input  logic                   clk,
   input  logic                   reset,
   input  ffe_pkg::code_word_t    codes,
   input  logic                   codes_valid,
   input  ffe_pkg::coef_wr_t      coef_wr,
   input  logic                   coef_wr_valid,
   output ffe_pkg::result_word_t  results,
   output logic                   results_valid
);

   ffe_pkg::weight_bank_t  weights;
   ffe_pkg::shift_bank_t   shifts;
   ffe_pkg::window_bank_t  windows;

   // Bit 0 marks a word in stage 1, bit 1 a word in stage 2
   logic [1:0] valid_q;

   ffe_pkg::result_t lane_result [`FFE_WIDTH];

   ffe_coef_regs coef_regs_i (
      .clk           (clk),
      .reset         (reset),
      .coef_wr       (coef_wr),
      .coef_wr_valid (coef_wr_valid),
      .weights       (weights),
      .shifts        (shifts)
   );

   ffe_tap_window tap_window_i (
      .clk         (clk),
      .reset       (reset),
      .codes       (codes),
      .codes_valid (codes_valid),
      .windows     (windows)
   );

   // A new word may enter while the previous one is in stage 2
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= '0;
      end else begin
         valid_q <= {valid_q[0], codes_valid};
      end
   end

   assign results_valid = valid_q[1];

   for (genvar l = 0; l < `FFE_WIDTH; l++) begin : g_lane
      ffe_pkg::tap_weights_t lane_weights;

      // The table is stored [tap][lane], pick out this lane's column
      always_comb begin
         for (int t = 0; t < `FFE_LENGTH; t++) begin
            lane_weights[t] = weights[t][l];
         end
      end

      ffe_lane lane_i (
         .clk       (clk),
         .reset     (reset),
         .window    (windows[l]),
         .weights   (lane_weights),
         .shift     (shifts[l]),
         .in_valid  (codes_valid),
         .mid_valid (valid_q[0]),
         .result    (lane_result[l])
      );
   end

   always_comb begin
      for (int l = 0; l < `FFE_WIDTH; l++) begin
         results.result[l] = lane_result[l];  // Lane order matches the code order
      end
   end

endmodule

/* src/ffe_lane.sv */
`timescale 1ns/1ps

`include "ffe_consts.svh"

// Two-stage equalizer datapath for a single lane.
// Stage 1 registers the tap products, stage 2 adds them up, applies the
// arithmetic right shift and clamps to the result range.
module ffe_lane (
   input  logic                   clk,
   input  logic                   reset,
   input  ffe_pkg::window_t       window,
   input  ffe_pkg::tap_weights_t  weights,
   input  ffe_pkg::shift_t        shift,
   input  logic                   in_valid,
   input  logic                   mid_valid,
   output ffe_pkg::result_t       result
);

   // Limits of result_t, sign extended to the accumulator width
   localparam ffe_pkg::acc_t RESULT_MAX =
      {{(`FFE_ACC_BITS - `FFE_RESULT_BITS + 1){1'b0}}, {(`FFE_RESULT_BITS - 1){1'b1}}};
   localparam ffe_pkg::acc_t RESULT_MIN =
      {{(`FFE_ACC_BITS - `FFE_RESULT_BITS + 1){1'b1}}, {(`FFE_RESULT_BITS - 1){1'b0}}};

   ffe_pkg::acc_t products [`FFE_LENGTH];  // Stage 1 registers

   ffe_pkg::acc_t sum;
   ffe_pkg::acc_t shifted;
   ffe_pkg::result_t clamped;

   // Both operands are widened before the multiply so the product keeps its sign
   always_ff @(posedge clk) begin
      if (in_valid) begin
         for (int t = 0; t < `FFE_LENGTH; t++) begin
            products[t] <= ffe_pkg::acc_t'(window[t]) * ffe_pkg::acc_t'(weights[t]);
         end
      end
   end

   always_comb begin
      sum = '0;
      for (int t = 0; t < `FFE_LENGTH; t++) begin
         sum = sum + products[t];
      end
   end

   // Signed operand, so >>> fills with the sign bit
   always_comb begin
      shifted = sum >>> shift;
   end

   always_comb begin
      if (shifted > RESULT_MAX) begin
         clamped = RESULT_MAX[`FFE_RESULT_BITS-1:0];  // Positive limit
      end else if (shifted < RESULT_MIN) begin
         clamped = RESULT_MIN[`FFE_RESULT_BITS-1:0];  // Negative limit
      end else begin
         clamped = shifted[`FFE_RESULT_BITS-1:0];
      end
   end

   // Stage 2, the result holds between words
   always_ff @(posedge clk) begin
      if (reset) begin
         result <= '0;
      end else if (mid_valid) begin
         result <= clamped;
      end
   end

endmodule

/* src/ffe_tap_window.sv */
`timescale 1ns/1ps

`include "ffe_consts.svh"

// Builds the tap window of every lane from the incoming word and the
// tail of the previous words. The windows are combinational, only the
// history is registered.
module ffe_tap_window (
   input  logic                   clk,
   input  logic                   reset,
   input  ffe_pkg::code_word_t    codes,
   input  logic                   codes_valid,
   output ffe_pkg::window_bank_t  windows
);

   localparam int HIST_LEN   = `FFE_LENGTH - 1;
   localparam int STREAM_LEN = `FFE_WIDTH + HIST_LEN;

   // Last HIST_LEN codes of the serial stream, hist[HIST_LEN-1] is the newest
   ffe_pkg::code_t [HIST_LEN-1:0] hist;

   // History followed by the new word, oldest code at index 0
   ffe_pkg::code_t [STREAM_LEN-1:0] stream;

   always_comb begin
      stream[HIST_LEN-1:0] = hist;
      stream[STREAM_LEN-1:HIST_LEN] = codes.code;
   end

   // Lane l sits at stream position HIST_LEN+l and looks back from there
   always_comb begin
      for (int l = 0; l < `FFE_WIDTH; l++) begin
         for (int t = 0; t < `FFE_LENGTH; t++) begin
            windows[l][t] = stream[HIST_LEN + l - t];
         end
      end
   end

   // Keep the newest codes of the word for the next one
   // This assumes HIST_LEN does not exceed FFE_WIDTH
   always_ff @(posedge clk) begin
      if (reset) begin
         hist <= '0;
      end else if (codes_valid) begin
         hist <= stream[STREAM_LEN-1:`FFE_WIDTH];
      end
   end

endmodule

/* src/ffe_coef_regs.sv */
`timescale 1ns/1ps

`include "ffe_consts.svh"

// Holds every tap weight and every lane shift until it is written again.
// A write lands on the edge that samples the strobe, so the next word
// already sees the new value.
module ffe_coef_regs (
   input  logic                   clk,
   input  logic                   reset,
   input  ffe_pkg::coef_wr_t      coef_wr,
   input  logic                   coef_wr_valid,
   output ffe_pkg::weight_bank_t  weights,
   output ffe_pkg::shift_bank_t   shifts
);

   logic tap_in_range;
   logic wr_weight;
   logic wr_shift;

   // Decode one strobe into at most one register update
   always_comb begin
      tap_in_range = (coef_wr.tap < `FFE_LENGTH);
      wr_shift = coef_wr_valid && (coef_wr.kind == `FFE_KIND_SHIFT);
      wr_weight = coef_wr_valid && (coef_wr.kind == `FFE_KIND_WEIGHT) && tap_in_range;
   end

   // Weight table, indexed [tap][lane]
   always_ff @(posedge clk) begin
      if (reset) begin
         weights <= '0;
      end else if (wr_weight) begin
         weights[coef_wr.tap][coef_wr.lane] <= coef_wr.value;
      end
   end

   // The tap field plays no part in a shift write
   always_ff @(posedge clk) begin
      if (reset) begin
         shifts <= '0;
      end else if (wr_shift) begin
         shifts[coef_wr.lane] <= coef_wr.value[`FFE_SHIFT_BITS-1:0];  // Upper value bits dropped
      end
   end

endmodule

/* src/ffe_pkg.sv */
`include "ffe_consts.svh"

package ffe_pkg;

   // Scalar quantities of the datapath
   typedef logic signed [`FFE_CODE_BITS-1:0]   code_t;
   typedef logic signed [`FFE_WEIGHT_BITS-1:0] weight_t;
   typedef logic signed [`FFE_RESULT_BITS-1:0] result_t;
   typedef logic        [`FFE_SHIFT_BITS-1:0]  shift_t;
   typedef logic signed [`FFE_ACC_BITS-1:0]    acc_t;

   typedef logic [`FFE_TAP_IDX_BITS-1:0]  tap_idx_t;
   typedef logic [`FFE_LANE_IDX_BITS-1:0] lane_idx_t;

   // One received word, code[0] is the oldest code of the word
   typedef struct packed {
      code_t [`FFE_WIDTH-1:0] code;
   } code_word_t;

   // One equalized word, same lane order as the codes
   typedef struct packed {
      result_t [`FFE_WIDTH-1:0] result;
   } result_word_t;

   // Index 0 is the current code, index i the code i places earlier
   typedef code_t [`FFE_LENGTH-1:0] window_t;
   typedef window_t [`FFE_WIDTH-1:0] window_bank_t;

   // Weights of one lane, and the whole table indexed [tap][lane]
   typedef weight_t [`FFE_LENGTH-1:0] tap_weights_t;
   typedef weight_t [`FFE_LENGTH-1:0][`FFE_WIDTH-1:0] weight_bank_t;

   typedef shift_t [`FFE_WIDTH-1:0] shift_bank_t;

   // Configuration write, value[FFE_SHIFT_BITS-1:0] carries a shift
   typedef struct packed {
      logic      kind;   // FFE_KIND_WEIGHT or FFE_KIND_SHIFT
      tap_idx_t  tap;
      lane_idx_t lane;
      weight_t   value;
   } coef_wr_t;

endpackage

/* src/ffe_consts.svh */
`ifndef FFE_CONSTS_SVH
`define FFE_CONSTS_SVH

// Lanes per clock word and taps per lane
`define FFE_WIDTH         4
`define FFE_LENGTH        3

// Signed datapath widths
`define FFE_CODE_BITS     8
`define FFE_WEIGHT_BITS   10
`define FFE_RESULT_BITS   10
`define FFE_SHIFT_BITS    4

// Two guard bits cover the sum of FFE_LENGTH full-scale products
`define FFE_ACC_BITS      (`FFE_CODE_BITS + `FFE_WEIGHT_BITS + 2)

// Index fields of a configuration write
`define FFE_TAP_IDX_BITS  2
`define FFE_LANE_IDX_BITS 2

`define FFE_KIND_WEIGHT   1'b0  // Write goes to one tap weight
`define FFE_KIND_SHIFT    1'b1  // Write goes to one lane shift

`endif
